/* logic/network_settings.svh */
`ifndef NETWORK_SETTINGS_SVH
`define NETWORK_SETTINGS_SVH

`define ACTIVATION_COUNT 15
`define NODE_COUNT 4

`define DATA_WIDTH 32
`define ADDR_WIDTH 8

`define ADDR_ACT_BASE 8'h00
`define ADDR_START 8'h3C
`define ADDR_RESULT_BASE 8'h40
`define ADDR_STATUS 8'h50

`define RESP_OKAY 2'b00
`define RESP_SLVERR 2'b10

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Weight lists run from input 14 on the left down to input 0 on the right.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define NODE_WEIGHTS_0 {-8'sd7, -8'sd31, -8'sd31, -8'sd22, -8'sd29, 8'sd31, 8'sd3, 8'sd5, \
	8'sd18, 8'sd31, -8'sd31, 8'sd0, -8'sd7, 8'sd18, -8'sd3}
`define NODE_WEIGHTS_1 {8'sd12, -8'sd4, 8'sd27, 8'sd9, -8'sd15, 8'sd2, -8'sd30, 8'sd21, \
	-8'sd6, 8'sd14, 8'sd25, -8'sd11, 8'sd7, -8'sd19, 8'sd16}
`define NODE_WEIGHTS_2 {-8'sd20, 8'sd8, 8'sd1, -8'sd26, 8'sd13, 8'sd29, -8'sd2, -8'sd17, \
	8'sd24, -8'sd9, 8'sd4, 8'sd30, -8'sd23, 8'sd11, 8'sd6}
`define NODE_WEIGHTS_3 {8'sd31, 8'sd31, 8'sd28, 8'sd22, 8'sd19, 8'sd26, 8'sd30, 8'sd24, \
	8'sd17, 8'sd29, 8'sd21, 8'sd31, 8'sd25, 8'sd23, 8'sd27}
`define NODE_BIAS_0 -16'sd512
`define NODE_BIAS_1 16'sd256
`define NODE_BIAS_2 -16'sd1024
`define NODE_BIAS_3 16'sd96

`endif

/* logic/networkPkg.sv */
`include "network_settings.svh"

package networkPkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Scalar values of the datapath.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef logic signed [7:0] activation_t;
	typedef logic signed [7:0] weight_t;
	typedef logic signed [15:0] product_t;
	typedef logic signed [22:0] accum_t; // Holds fifteen products plus the bias.
	typedef logic [7:0] nodeOut_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Vectors passed between the blocks.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef activation_t [`ACTIVATION_COUNT-1:0] activationVector_t;
	typedef weight_t [`ACTIVATION_COUNT-1:0] weightVector_t;
	typedef nodeOut_t [`NODE_COUNT-1:0] resultVector_t;

	typedef enum logic
	{
		IDLE,
		RESPOND
	} respState_t;

endpackage

/* logic/axiLiteBus.sv */
`include "network_settings.svh"

interface axiLiteBus;

	logic [`ADDR_WIDTH-1:0] awaddr;
	logic awvalid;
	logic awready;

	logic [`DATA_WIDTH-1:0] wdata;
	logic wvalid;
	logic wready;

	logic [1:0] bresp;
	logic bvalid;
	logic bready;

	logic [`ADDR_WIDTH-1:0] araddr;
	logic arvalid;
	logic arready;

	logic [`DATA_WIDTH-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	modport slaveWrite (input awaddr, awvalid, wdata, wvalid, bready,
		output awready, wready, bresp, bvalid);
	modport slaveRead (input araddr, arvalid, rready,
		output arready, rdata, rresp, rvalid);
	modport master (output awaddr, awvalid, wdata, wvalid, bready, araddr, arvalid, rready,
		input awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid);

endinterface

/* logic/activationLoader.sv */
`include "network_settings.svh"

module activationLoader
(
	input logic clk,
	input logic reset,
	axiLiteBus.slaveWrite bus,
	output networkPkg::activationVector_t activations,
	output logic start
);
	import networkPkg::*;

	localparam int actIndexWidth = $clog2(`ACTIVATION_COUNT);

	respState_t state;
	logic writeFire;
	logic [`ADDR_WIDTH-1:0] actOffset;
	logic [`ADDR_WIDTH-3:0] actWord;
	logic actHit;
	logic startHit;

	// Address and data are taken together, so both readies follow both valids.
	assign writeFire = (state == IDLE) && bus.awvalid && bus.wvalid;
	assign bus.awready = writeFire;
	assign bus.wready = writeFire;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Address decode.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign actOffset = bus.awaddr - `ADDR_ACT_BASE;
	assign actWord = actOffset[`ADDR_WIDTH-1:2];
	assign actHit = (actOffset[1:0] == 2'b00) && (actWord < `ACTIVATION_COUNT);
	assign startHit = (bus.awaddr == `ADDR_START);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= IDLE;
			bus.bvalid <= 1'b0;
			bus.bresp <= `RESP_OKAY;
			start <= 1'b0;
			activations <= '0;
		end
		else
		begin
			start <= 1'b0; // Single-cycle pulse.
			case (state)
				IDLE:
				begin
					if (writeFire)
					begin
						bus.bvalid <= 1'b1;
						state <= RESPOND;
						if (actHit)
						begin
							activations[actWord[actIndexWidth-1:0]] <= bus.wdata[7:0];
							bus.bresp <= `RESP_OKAY;
						end
						else if (startHit)
						begin
							start <= 1'b1;
							bus.bresp <= `RESP_OKAY;
						end
						else
						begin
							bus.bresp <= `RESP_SLVERR; // Unmapped, nothing is written.
						end
					end
				end
				RESPOND:
				begin
					if (bus.bready)
					begin
						bus.bvalid <= 1'b0;
						state <= IDLE;
					end
				end
				default:
				begin
					bus.bvalid <= 1'b0;
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

/* logic/neuronNode.sv */
`include "network_settings.svh"

module neuronNode
#(
	parameter networkPkg::weightVector_t weights = '0,
	parameter networkPkg::product_t bias = '0
)
(
	input logic clk,
	input logic reset,
	input networkPkg::activationVector_t activations,
	output networkPkg::nodeOut_t result
);
	import networkPkg::*;

	activationVector_t activationsReg;
	product_t products [`ACTIVATION_COUNT];
	accum_t sumNext;
	accum_t sumReg;
	nodeOut_t rounded;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Multiply-accumulate.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb
	begin
		for (int i = 0; i < `ACTIVATION_COUNT; i++)
		begin
			products[i] = activationsReg[i] * weights[i]; // Signed 8x8 into 16 bits.
		end
	end

	always_comb
	begin
		sumNext = accum_t'(bias);
		for (int i = 0; i < `ACTIVATION_COUNT; i++)
		begin
			sumNext = sumNext + accum_t'(products[i]);
		end
	end

	// Bit 5 is the half-LSB of the output scale, so adding it rounds to nearest.
	assign rounded = sumReg[13:6] + {7'd0, sumReg[5]};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Three register stages.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			activationsReg <= '0;
			sumReg <= '0;
			result <= '0;
		end
		else
		begin
			activationsReg <= activations;
			sumReg <= sumNext;
			if (sumReg[22])
			begin
				result <= 8'd0; // Negative sums are rectified.
			end
			else if (sumReg[21:13] != 9'd0)
			begin
				result <= 8'd127; // Saturate.
			end
			else
			begin
				result <= rounded;
			end
		end
	end

endmodule

/* logic/neuronLayer.sv */
`include "network_settings.svh"

module neuronLayer
(
	input logic clk,
	input logic reset,
	input networkPkg::activationVector_t activations,
	input logic start,
	output networkPkg::resultVector_t results,
	output logic resultValid
);
	import networkPkg::*;

	localparam weightVector_t nodeWeights [`NODE_COUNT] = '{
		`NODE_WEIGHTS_0,
		`NODE_WEIGHTS_1,
		`NODE_WEIGHTS_2,
		`NODE_WEIGHTS_3
	};

	localparam product_t nodeBias [`NODE_COUNT] = '{
		`NODE_BIAS_0,
		`NODE_BIAS_1,
		`NODE_BIAS_2,
		`NODE_BIAS_3
	};

	logic [2:0] validPipe;

	for (genvar n = 0; n < `NODE_COUNT; n++)
	begin : node
		neuronNode
		#(
			.weights(nodeWeights[n]),
			.bias(nodeBias[n])
		)
		i_neuronNode
		(
			.clk(clk),
			.reset(reset),
			.activations(activations),
			.result(results[n])
		);
	end

	// Matches the three register stages inside each node.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validPipe <= '0;
		end
		else
		begin
			validPipe <= {validPipe[1:0], start};
		end
	end

	assign resultValid = validPipe[2];

endmodule

/* logic/resultReader.sv */
`include "network_settings.svh"

module resultReader
(
	input logic clk,
	input logic reset,
	axiLiteBus.slaveRead bus,
	input logic start,
	input networkPkg::resultVector_t results,
	input logic resultValid
);
	import networkPkg::*;

	localparam int nodeIndexWidth = $clog2(`NODE_COUNT);

	respState_t state;
	resultVector_t captured;
	logic done;
	logic readFire;
	logic [`ADDR_WIDTH-1:0] resOffset;
	logic [`ADDR_WIDTH-3:0] resWord;
	logic resHit;
	logic statusHit;
	logic [`DATA_WIDTH-1:0] readData;
	logic [1:0] readResp;

	assign bus.arready = (state == IDLE);
	assign readFire = bus.arready && bus.arvalid;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Address decode and read mux.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign resOffset = bus.araddr - `ADDR_RESULT_BASE;
	assign resWord = resOffset[`ADDR_WIDTH-1:2];
	assign resHit = (resOffset[1:0] == 2'b00) && (resWord < `NODE_COUNT);
	assign statusHit = (bus.araddr == `ADDR_STATUS);

	always_comb
	begin
		readData = '0;
		readResp = `RESP_OKAY;
		if (resHit)
			readData[$bits(nodeOut_t)-1:0] = captured[resWord[nodeIndexWidth-1:0]];
		else if (statusHit)
			readData[0] = done;
		else
			readResp = `RESP_SLVERR;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= IDLE;
			bus.rvalid <= 1'b0;
			captured <= '0;
			done <= 1'b0;
		end
		else
		begin
			if (resultValid)
			begin
				captured <= results;
				done <= 1'b1; // Takes priority over a start in the same cycle.
			end
			else if (start)
			begin
				done <= 1'b0;
			end

			if (readFire)
			begin
				bus.rvalid <= 1'b1;
				state <= RESPOND;
			end
			else if ((state == RESPOND) && bus.rready)
			begin
				bus.rvalid <= 1'b0;
				state <= IDLE;
			end
		end
	end

	// Payload only changes on an accepted address, so it holds through back-pressure.
	always_ff @(posedge clk)
	begin
		if (readFire)
		begin
			bus.rdata <= readData;
			bus.rresp <= readResp;
		end
	end

endmodule

/* logic/neuralLayerTop.sv */
`include "network_settings.svh"

module neuralLayerTop
(
	input logic clk,
	input logic reset,
	input logic [`ADDR_WIDTH-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [`DATA_WIDTH-1:0] wdata,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [`ADDR_WIDTH-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [`DATA_WIDTH-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready
);
	import networkPkg::*;

	activationVector_t activations;
	resultVector_t results;
	logic start;
	logic resultValid;

	axiLiteBus bus ();

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Plain ports onto the bus.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign bus.awaddr = awaddr;
	assign bus.awvalid = awvalid;
	assign awready = bus.awready;
	assign bus.wdata = wdata;
	assign bus.wvalid = wvalid;
	assign wready = bus.wready;
	assign bresp = bus.bresp;
	assign bvalid = bus.bvalid;
	assign bus.bready = bready;
	assign bus.araddr = araddr;
	assign bus.arvalid = arvalid;
	assign arready = bus.arready;
	assign rdata = bus.rdata;
	assign rresp = bus.rresp;
	assign rvalid = bus.rvalid;
	assign bus.rready = rready;

	activationLoader i_activationLoader
	(
		.clk(clk),
		.reset(reset),
		.bus(bus.slaveWrite),
		.activations(activations),
		.start(start)
	);

	neuronLayer i_neuronLayer
	(
		.clk(clk),
		.reset(reset),
		.activations(activations),
		.start(start),
		.results(results),
		.resultValid(resultValid)
	);

	resultReader i_resultReader
	(
		.clk(clk),
		.reset(reset),
		.bus(bus.slaveRead),
		.start(start),
		.results(results),
		.resultValid(resultValid)
	);

endmodule

/* verification/clockGen.sv */
module clockGen
(
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk; // Period of 40.
	end

	initial
	begin
		reset = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0; // Released between edges after four active cycles.
	end

endmodule

/* verification/neuralLayerTb.sv */
`include "network_settings.svh"

module neuralLayerTb;
	import networkPkg::*;

	localparam logic [31:0] seed = 32'h865a8170;
	localparam int randomSetCount = 200;
	localparam int extremeSetCount = 20;
	localparam int overlapRounds = 4;
	localparam int inferenceCount = randomSetCount + 2 * extremeSetCount + 2 * overlapRounds + 2;
	localparam int cycleBudget = 150; // Sixteen writes, status polls and four reads.
	localparam int cycleLimit = inferenceCount * cycleBudget * 2;

	localparam logic [8*`ACTIVATION_COUNT-1:0] weightTable [`NODE_COUNT] = '{
		`NODE_WEIGHTS_0,
		`NODE_WEIGHTS_1,
		`NODE_WEIGHTS_2,
		`NODE_WEIGHTS_3
	};
	localparam int biasTable [`NODE_COUNT] = '{
		`NODE_BIAS_0,
		`NODE_BIAS_1,
		`NODE_BIAS_2,
		`NODE_BIAS_3
	};

	logic clk;
	logic reset;
	logic [`ADDR_WIDTH-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [`DATA_WIDTH-1:0] wdata;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [`ADDR_WIDTH-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [`DATA_WIDTH-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	logic [31:0] rngState = seed;
	int checkCount = 0;
	int errorCount = 0;
	int cycleCount = 0;
	activationVector_t lastActs;
	logic [7:0] badWriteAddrs [6] = '{8'h02, 8'h3D, 8'h40, 8'h4C, 8'h50, 8'hFC};
	logic [7:0] badReadAddrs [6] = '{8'h00, 8'h38, 8'h3C, 8'h42, 8'h54, 8'hFF};

	clockGen i_clockGen
	(
		.clk(clk),
		.reset(reset)
	);

	neuralLayerTop i_neuralLayerTop (.*);

	always @(posedge clk)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("Timeout: the run did not finish within %0d cycles.", cycleLimit);
			$display("Some tests failed");
			$finish;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Random stimulus and the node model.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [31:0] nextRandom();
		rngState = rngState * 32'd1664525 + 32'd1013904223;
		return rngState;
	endfunction

	function automatic int randomDelay();
		logic [31:0] r;
		r = nextRandom();
		return int'(r[31:30]); // Upper bits are the better ones in an LCG.
	endfunction

	function automatic activationVector_t randomActivations();
		activationVector_t acts;
		logic [31:0] r;
		for (int i = 0; i < `ACTIVATION_COUNT; i++)
		begin
			r = nextRandom();
			acts[i] = activation_t'(r[31:24]);
		end
		return acts;
	endfunction

	function automatic activationVector_t extremeActivations();
		activationVector_t acts;
		logic [31:0] r;
		for (int i = 0; i < `ACTIVATION_COUNT; i++)
		begin
			r = nextRandom();
			case (r[31:30])
				2'd0: acts[i] = 8'h7F;
				2'd1: acts[i] = 8'h80;
				2'd2: acts[i] = 8'h81;
				default: acts[i] = activation_t'(r[23:16]);
			endcase
		end
		return acts;
	endfunction

	function automatic activationVector_t uniformActivations();
		activationVector_t acts;
		logic [31:0] r;
		r = nextRandom();
		for (int i = 0; i < `ACTIVATION_COUNT; i++)
		begin
			acts[i] = activation_t'(r[31:24]);
		end
		return acts;
	endfunction

	function automatic nodeOut_t modelNode(int node, activationVector_t acts);
		int sum;
		int weight;
		logic [7:0] weightBits;
		sum = biasTable[node];
		for (int i = 0; i < `ACTIVATION_COUNT; i++)
		begin
			weightBits = weightTable[node][8*i +: 8]; // Input 0 sits in the low byte.
			weight = int'($signed(weightBits));
			sum = sum + weight * int'(acts[i]);
		end
		if (sum < 0)
			return 8'd0;
		if (sum >= 8192)
			return 8'd127; // One of bits 21 to 13 is set.
		return nodeOut_t'((sum >> 6) + ((sum >> 5) & 1));
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// AXI4-Lite master. Each task starts and ends on a falling edge.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic writeWord(input logic [7:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		int delay;
		int lead;
		awaddr = addr;
		wdata = data;
		lead = randomDelay();
		awvalid = (lead != 1);
		wvalid = (lead != 0);
		if (lead < 2)
		begin
			@(posedge clk);
			checkValue("awready", 0, awready); // Only one of the two valids is high.
			checkValue("wready", 0, wready);
			@(negedge clk);
			awvalid = 1'b1;
			wvalid = 1'b1;
		end
		@(posedge clk);
		checkValue("awready", 1, awready);
		checkValue("wready", 1, wready);
		@(negedge clk);
		while (!bvalid)
			@(negedge clk);
		checkValue("awready", 0, awready); // Valids are still high while the response waits.
		checkValue("wready", 0, wready);
		awvalid = 1'b0;
		wvalid = 1'b0;
		resp = bresp;
		delay = randomDelay();
		repeat (delay)
		begin
			@(negedge clk);
			checkValue("bvalid", 1, bvalid); // Response must hold under back-pressure.
			checkValue("bresp", resp, bresp);
		end
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
		checkValue("bvalid", 0, bvalid);
	endtask

	task automatic readWord(input logic [7:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int delay;
		checkValue("arready", 1, arready);
		araddr = addr;
		arvalid = 1'b1;
		@(negedge clk);
		while (!rvalid)
			@(negedge clk);
		checkValue("arready", 0, arready); // No new address while the data waits.
		arvalid = 1'b0;
		data = rdata;
		resp = rresp;
		delay = randomDelay();
		repeat (delay)
		begin
			@(negedge clk);
			checkValue("rvalid", 1, rvalid);
			checkValue("rdata", data, rdata);
			checkValue("rresp", resp, rresp);
		end
		rready = 1'b1;
		@(negedge clk);
		rready = 1'b0;
		checkValue("rvalid", 0, rvalid);
	endtask

	task automatic loadActivations(input activationVector_t acts);
		logic [31:0] upper;
		logic [1:0] resp;
		for (int i = 0; i < `ACTIVATION_COUNT; i++)
		begin
			upper = nextRandom(); // Only the low byte is stored.
			writeWord(`ADDR_ACT_BASE + 4 * i, {upper[31:8], acts[i]}, resp);
			checkValue("bresp", `RESP_OKAY, resp);
		end
	endtask

	task automatic pulseStart();
		logic [1:0] resp;
		writeWord(`ADDR_START, nextRandom(), resp);
		checkValue("bresp", `RESP_OKAY, resp);
	endtask

	task automatic pollDone();
		logic [31:0] data;
		logic [1:0] resp;
		data = '0;
		while (data[0] !== 1'b1)
		begin
			readWord(`ADDR_STATUS, data, resp);
			checkValue("status rresp", `RESP_OKAY, resp);
			checkValue("status upper bits", 0, data >> 1);
		end
	endtask

	task automatic checkResults(input activationVector_t acts);
		logic [31:0] data;
		logic [1:0] resp;
		for (int n = 0; n < `NODE_COUNT; n++)
		begin
			readWord(`ADDR_RESULT_BASE + 4 * n, data, resp);
			checkValue("result rresp", `RESP_OKAY, resp);
			checkValue($sformatf("result%0d", n), {24'h0, modelNode(n, acts)}, data);
		end
	endtask

	task automatic runInference(input activationVector_t acts);
		loadActivations(acts);
		pulseStart();
		pollDone();
		checkResults(acts);
		lastActs = acts;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Test sequences.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic checkAfterReset();
		logic [31:0] data;
		logic [1:0] resp;
		checkValue("bvalid", 0, bvalid);
		checkValue("rvalid", 0, rvalid);
		readWord(`ADDR_STATUS, data, resp);
		checkValue("status rresp", `RESP_OKAY, resp);
		checkValue("status", 0, data);
		for (int n = 0; n < `NODE_COUNT; n++)
		begin
			readWord(`ADDR_RESULT_BASE + 4 * n, data, resp);
			checkValue("result rresp", `RESP_OKAY, resp);
			checkValue($sformatf("result%0d", n), 0, data);
		end
	endtask

	task automatic checkUnmapped();
		logic [31:0] data;
		logic [1:0] resp;
		foreach (badWriteAddrs[i])
		begin
			writeWord(badWriteAddrs[i], nextRandom(), resp);
			checkValue("bresp", `RESP_SLVERR, resp);
		end
		foreach (badReadAddrs[i])
		begin
			readWord(badReadAddrs[i], data, resp);
			checkValue("rresp", `RESP_SLVERR, resp);
			checkValue("rdata", 0, data);
		end
		checkResults(lastActs);
		pulseStart(); // The activations must have survived the rejected writes.
		pollDone();
		checkResults(lastActs);
	endtask

	task automatic startWhileBusy();
		logic [31:0] data;
		logic [1:0] resp;
		activationVector_t first;
		activationVector_t second;
		first = randomActivations();
		second = extremeActivations();
		loadActivations(first);
		pulseStart();
		loadActivations(second);
		pulseStart();
		readWord(`ADDR_STATUS, data, resp);
		checkValue("status rresp", `RESP_OKAY, resp);
		checkValue("status upper bits", 0, data >> 1);
		if (data[0])
			checkResults(second); // Done early means the second set is already captured.
		pollDone();
		checkResults(second);
		lastActs = second;
	endtask

	initial
	begin
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		@(negedge clk);
		while (reset)
			@(negedge clk);

		checkAfterReset();
		repeat (randomSetCount) runInference(randomActivations());
		repeat (extremeSetCount)
		begin
			runInference(extremeActivations());
			runInference(uniformActivations());
		end
		checkUnmapped();
		repeat (overlapRounds) startWhileBusy();

		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

/* project.f */
+incdir+logic
logic/networkPkg.sv
logic/axiLiteBus.sv
logic/activationLoader.sv
logic/neuronNode.sv
logic/neuronLayer.sv
logic/resultReader.sv
logic/neuralLayerTop.sv
verification/clockGen.sv
verification/neuralLayerTb.sv

/* Bender.yml */
package:
  name: neural_layer

sources:
  - include_dirs:
      - logic
    files:
      - logic/networkPkg.sv
      - logic/axiLiteBus.sv
      - logic/activationLoader.sv
      - logic/neuronNode.sv
      - logic/neuronLayer.sv
      - logic/resultReader.sv
      - logic/neuralLayerTop.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/clockGen.sv
      - verification/neuralLayerTb.sv
